// ==== sim.f ====
verilog/led_ctrl_pkg.sv
verilog/uart_rx.sv
verilog/cmd_decoder.sv
verilog/frame_ram.sv
verilog/ctrl_regs.sv
verilog/led_ctrl_top.sv
tests/led_ctrl_checker.sv
tests/led_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module led_ctrl_tb -f sim.f -o led_ctrl_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/led_ctrl_sim > sim.log 2>&1
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tests/led_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_ctrl_tb;
    import led_ctrl_pkg::*;

    // random command picks; the last two characters are not commands.
    localparam logic [8*16-1:0] cmd_set = "RrGgBb12345609x7";

    logic                  clk_in;
    logic                  reset;
    logic                  uart_line;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;
    disp_en_t              disp_en;
    logic [15:0]           lfsr_q;
    disp_en_t              exp_disp;
    logic [1:0]            exp_state;
    logic [4:0]            exp_row;
    logic [6:0]            exp_col;
    logic [7:0]            exp_count;
    logic [div_w-1:0]      exp_div;
    logic [data_w-1:0]     exp_mem [1 << ram_addr_w];
    logic [4:0]            line_rows [$];
    logic [ram_addr_w-1:0] addr;
    int                    disp_errs;
    int                    byte_errs;
    int                    count_errs;
    int                    wait_errs;

    led_ctrl_top u_dut (
        .clk_in  (clk_in),
        .reset   (reset),
        .uart_rx (uart_line),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .disp_en (disp_en)
    );

    bind ctrl_regs led_ctrl_checker u_bus_chk (
        .clk_in  (clk_in),
        .reset   (reset),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .rx_byte ('0),
        .ram_wr  ('0)
    );

    bind cmd_decoder led_ctrl_checker u_dec_chk (
        .clk_in  (clk_in),
        .reset   (reset),
        .wb_req  ('0),
        .wb_rsp  ('0),
        .rx_byte (rx_byte),
        .ram_wr  (ram_wr)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // galois form of x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[6:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [7:0] cmd_char(input logic [3:0] idx);
        return cmd_set[{~idx, 3'b000} +: 8];
    endfunction

    // pixel pairs land in reverse column order with the pair order kept.
    function automatic logic [ram_addr_w-1:0] pixel_addr(input logic [4:0] row,
                                                         input logic [6:0] col);
        int pair;
        pair = 63 - int'(col) / 2;
        return ram_addr_w'(int'(row) * line_bytes + pair * 2 + int'(col) % 2);
    endfunction

    task automatic check_disp(input string name, input disp_en_t got, input disp_en_t exp);
        if (got !== exp) begin
            disp_errs++;
            $display("CHECK FAILED at %0d ns: %s got %03h expected %03h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        if (got !== exp) begin
            byte_errs++;
            $display("CHECK FAILED at %0d ns: %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            count_errs++;
            $display("CHECK FAILED at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [wb_adr_w-1:0] adr,
                             input logic [7:0] wdat, output logic [7:0] rdat);
        int waited;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk_in);
        while (!wb_rsp.ack && waited < 20) begin
            @(negedge clk_in);
            waited++;
        end
        if (!wb_rsp.ack) begin
            wait_errs++;
            $display("no Wishbone ack for address %04h after %0d cycles", adr, waited);
        end
        rdat = wb_rsp.dat;
        // the strobe stays up over the edge that samples the ack.
        @(negedge clk_in);
        wb_req = '0;
        @(negedge clk_in);
    endtask

    task automatic read_word(input logic [wb_adr_w-1:0] adr, output logic [7:0] rdat);
        bus_cycle(1'b0, adr, 8'h00, rdat);
    endtask

    task automatic write_word(input logic [wb_adr_w-1:0] adr, input logic [7:0] wdat);
        logic [7:0] unused;
        bus_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        repeat (10) begin
            uart_line = frame[0];
            frame = frame >> 1;
            repeat (exp_div) @(negedge clk_in);
        end
    endtask

    task automatic wait_rx_idle();
        logic [7:0] got;
        int tries;
        tries = 0;
        read_word({5'b0, reg_status}, got);
        while (got[3] && tries < 40) begin
            read_word({5'b0, reg_status}, got);
            tries++;
        end
        if (got[3]) begin
            wait_errs++;
            $display("receiver still busy after %0d status polls", tries);
        end
    endtask

    task automatic model_byte(input logic [7:0] b);
        logic [2:0] k;
        if (exp_state == 2'd0) begin
            case (b)
                "R": exp_disp.rgb_enable[0] = 1'b1;
                "r": exp_disp.rgb_enable[0] = 1'b0;
                "G": exp_disp.rgb_enable[1] = 1'b1;
                "g": exp_disp.rgb_enable[1] = 1'b0;
                "B": exp_disp.rgb_enable[2] = 1'b1;
                "b": exp_disp.rgb_enable[2] = 1'b0;
                "1", "2", "3", "4", "5", "6": begin
                    k = 3'(54 - int'(b));
                    exp_disp.brightness_enable[k] = ~exp_disp.brightness_enable[k];
                end
                "0": exp_disp.brightness_enable = '0;
                "9": exp_disp.brightness_enable = '1;
                "L": exp_state = 2'd1;
                default: ;
            endcase
        end else if (exp_state == 2'd1) begin
            exp_row = b[4:0];
            exp_col = 7'd127;
            exp_state = 2'd2;
        end else begin
            exp_mem[pixel_addr(exp_row, exp_col)] = b;
            if (exp_col == 7'd0) begin
                exp_state = 2'd0;
                exp_count = exp_count + 8'd1;
            end
            exp_col = exp_col - 7'd1;
        end
    endtask

    task automatic deliver(input logic [7:0] b);
        send_byte(b);
        wait_rx_idle();
        model_byte(b);
        check_disp("disp_en", disp_en, exp_disp);
    endtask

    task automatic verify_status();
        logic [7:0] got;
        read_word({5'b0, reg_status}, got);
        check_byte("status", got, {4'b0000, 1'b0, exp_disp.rgb_enable});
        read_word(13'h100, got);
        check_byte("status brightness", got, {2'b00, exp_disp.brightness_enable});
    endtask

    task automatic send_commands(input int n);
        logic [7:0] idx;
        for (int i = 0; i < n; i++) begin
            take_bits(4, idx);
            deliver(cmd_char(idx[3:0]));
            verify_status();
        end
    endtask

    // with mixed set, some pixel bytes look like commands and must not act as ones.
    task automatic send_line(input logic mixed);
        logic [7:0] v;
        logic [7:0] got;
        deliver("L");
        take_bits(8, v);
        deliver(v);
        line_rows.push_back(exp_row);
        for (int i = 0; i < line_bytes; i++) begin
            take_bits(8, v);
            if (mixed && i == 0) begin
                v = "r";
            end else if (mixed && (i % 4) == 0) begin
                v = cmd_char(v[3:0]);
            end
            deliver(v);
        end
        read_word({5'b0, reg_cmd_count}, got);
        check_count("cmd_count", got, exp_count);
    endtask

    initial begin
        logic [7:0] v;
        logic [7:0] got;
        lfsr_q = 16'd38560;
        disp_errs = 0;
        byte_errs = 0;
        count_errs = 0;
        wait_errs = 0;
        uart_line = 1'b1;
        wb_req = '0;
        reset = 1'b1;
        exp_disp = '1;
        exp_state = 2'd0;
        exp_row = '0;
        exp_col = '0;
        exp_count = 8'd0;
        exp_div = 8'd9;
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
        @(negedge clk_in);

        check_disp("disp_en", disp_en, exp_disp);
        read_word({5'b0, reg_cmd_count}, got);
        check_count("cmd_count", got, exp_count);
        read_word({5'b0, reg_divisor}, got);
        check_byte("divisor", got, exp_div);

        // any divisor from 4 to 12 keeps each sample inside its bit.
        take_bits(4, v);
        exp_div = 8'd4 + (v % 8'd9);
        write_word({5'b0, reg_divisor}, exp_div);
        read_word({5'b0, reg_divisor}, got);
        check_byte("divisor", got, exp_div);

        send_commands(30);
        send_line(1'b1);
        send_commands(30);
        send_line(1'b0);

        foreach (line_rows[r]) begin
            for (int c = 0; c < line_bytes; c++) begin
                addr = pixel_addr(line_rows[r], 7'(c));
                read_word({1'b1, addr}, got);
                check_byte($sformatf("frame[%03h]", addr), got, exp_mem[addr]);
            end
        end

        write_word({5'b0, reg_divisor}, 8'd0);
        exp_div = 8'd1;
        read_word({5'b0, reg_divisor}, got);
        check_byte("divisor", got, exp_div);

        $display("errors: disp_en %0d, byte %0d, cmd_count %0d, timeout %0d",
                 disp_errs, byte_errs, count_errs, wait_errs);
        if (disp_errs + byte_errs + count_errs + wait_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/led_ctrl_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_ctrl_checker (
    input logic                   clk_in,
    input logic                   reset,
    input led_ctrl_pkg::wb_req_t  wb_req,
    input led_ctrl_pkg::wb_rsp_t  wb_rsp,
    input led_ctrl_pkg::rx_byte_t rx_byte,
    input led_ctrl_pkg::ram_wr_t  ram_wr
);

    // the slave may only answer inside a live bus cycle.
    ack_in_cycle: assert property (@(posedge clk_in) disable iff (reset)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("ack raised without cyc and stb");

    ack_one_cycle: assert property (@(posedge clk_in) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack held for more than one cycle");

    // each received byte is a single strobe.
    strobe_one_cycle: assert property (@(posedge clk_in) disable iff (reset)
        rx_byte.valid |=> !rx_byte.valid)
        else $error("byte strobe held for more than one cycle");

    write_one_cycle: assert property (@(posedge clk_in) disable iff (reset)
        ram_wr.en |=> !ram_wr.en)
        else $error("frame RAM write enable held for more than one cycle");

endmodule

`default_nettype wire

// ==== verilog/led_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_ctrl_top (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   uart_rx,
    input  led_ctrl_pkg::wb_req_t  wb_req,
    output led_ctrl_pkg::wb_rsp_t  wb_rsp,
    output led_ctrl_pkg::disp_en_t disp_en
);
    import led_ctrl_pkg::*;

    rx_byte_t              rx_byte;
    logic                  rx_busy;
    ram_wr_t               ram_wr;
    logic [7:0]            cmd_count;
    logic [div_w-1:0]      ticks_per_bit;
    logic [ram_addr_w-1:0] ram_rd_addr;
    logic [data_w-1:0]     ram_rd_data;

    uart_rx u_uart_rx (
        .clk_in        (clk_in),
        .reset         (reset),
        .rx            (uart_rx),
        .ticks_per_bit (ticks_per_bit),
        .rx_byte       (rx_byte),
        .rx_busy       (rx_busy)
    );

    cmd_decoder u_cmd_decoder (
        .clk_in    (clk_in),
        .reset     (reset),
        .rx_byte   (rx_byte),
        .disp_en   (disp_en),
        .ram_wr    (ram_wr),
        .cmd_count (cmd_count)
    );

    frame_ram u_frame_ram (
        .clk_in  (clk_in),
        .ram_wr  (ram_wr),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

    ctrl_regs u_ctrl_regs (
        .clk_in        (clk_in),
        .reset         (reset),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .disp_en       (disp_en),
        .rx_busy       (rx_busy),
        .cmd_count     (cmd_count),
        .ticks_per_bit (ticks_per_bit),
        .ram_rd_addr   (ram_rd_addr),
        .ram_rd_data   (ram_rd_data)
    );

endmodule

`default_nettype wire

// ==== verilog/ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
    input  logic                                clk_in,
    input  logic                                reset,
    input  led_ctrl_pkg::wb_req_t               wb_req,
    output led_ctrl_pkg::wb_rsp_t               wb_rsp,
    input  led_ctrl_pkg::disp_en_t              disp_en,
    input  logic                                rx_busy,
    input  logic [7:0]                          cmd_count,
    output logic [led_ctrl_pkg::div_w-1:0]      ticks_per_bit,
    output logic [led_ctrl_pkg::ram_addr_w-1:0] ram_rd_addr,
    input  logic [7:0]                          ram_rd_data
);
    import led_ctrl_pkg::*;

    logic              req;
    logic              ram_sel;
    logic              pend;
    logic              ack;
    logic              div_wr;
    logic [data_w-1:0] rd_mux;
    logic [data_w-1:0] rd_data;

    assign req = wb_req.cyc && wb_req.stb;
    assign ram_sel = wb_req.adr[wb_adr_w-1];
    assign ram_rd_addr = wb_req.adr[ram_addr_w-1:0];
    assign div_wr = req && wb_req.we && !ram_sel && (wb_req.adr[7:0] == reg_divisor);

    always_comb begin
        rd_mux = '0;
        if (ram_sel) begin
            rd_mux = ram_rd_data;
        end else begin
            case (wb_req.adr[7:0])
                reg_status: begin
                    // address bit 8 selects the brightness view of the status word.
                    if (wb_req.adr[8]) begin
                        rd_mux = {2'b00, disp_en.brightness_enable};
                    end else begin
                        rd_mux = {4'b0000, rx_busy, disp_en.rgb_enable};
                    end
                end
                reg_divisor: rd_mux = ticks_per_bit;
                reg_cmd_count: rd_mux = cmd_count;
                default: rd_mux = '0;
            endcase
        end
    end

    // first edge registers the RAM read, second edge answers.
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pend <= 1'b0;
            ack <= 1'b0;
            ticks_per_bit <= default_ticks_per_bit;
        end else begin
            ack <= 1'b0;
            if (pend) begin
                pend <= 1'b0;
                ack <= req;
                if (div_wr) begin
                    ticks_per_bit <= (wb_req.dat == '0) ? div_w'(1) : wb_req.dat[div_w-1:0];
                end
            end else if (req && !ack) begin
                pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (pend) begin
            rd_data <= rd_mux;
        end
    end

    assign wb_rsp = '{ack: ack, dat: rd_data};

endmodule

`default_nettype wire

// ==== verilog/frame_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_ram (
    input  logic                                clk_in,
    input  led_ctrl_pkg::ram_wr_t               ram_wr,
    input  logic [led_ctrl_pkg::ram_addr_w-1:0] rd_addr,
    output logic [7:0]                          rd_data
);
    import led_ctrl_pkg::*;

    localparam int depth = 1 << ram_addr_w;

    logic [data_w-1:0] mem [depth];

    always_ff @(posedge clk_in) begin
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // read and write in the same cycle return the old byte.
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
    input  logic                   clk_in,
    input  logic                   reset,
    input  led_ctrl_pkg::rx_byte_t rx_byte,
    output led_ctrl_pkg::disp_en_t disp_en,
    output led_ctrl_pkg::ram_wr_t  ram_wr,
    output logic [7:0]             cmd_count
);
    import led_ctrl_pkg::*;

    localparam int col_w = $clog2(line_bytes);

    logic [1:0]            state;
    logic [4:0]            row;
    logic [col_w-1:0]      col;
    logic [ram_addr_w-1:0] pix_addr;
    logic                  wr_en;
    logic [ram_addr_w-1:0] wr_addr;
    logic [data_w-1:0]     wr_data;
    logic                  load_byte;

    // pixel pairs are stored in reverse column order, the low bit keeps the pair order.
    assign pix_addr = {row, ~col[col_w-1:1], col[0]};
    assign load_byte = rx_byte.valid && (state == dec_load);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= dec_idle;
            row <= '0;
            col <= '0;
            wr_en <= 1'b0;
            cmd_count <= '0;
            disp_en <= '1;
        end else begin
            wr_en <= 1'b0;
            if (rx_byte.valid) begin
                case (state)
                    dec_idle: begin
                        case (rx_byte.data)
                            "R": disp_en.rgb_enable[0] <= 1'b1;
                            "r": disp_en.rgb_enable[0] <= 1'b0;
                            "G": disp_en.rgb_enable[1] <= 1'b1;
                            "g": disp_en.rgb_enable[1] <= 1'b0;
                            "B": disp_en.rgb_enable[2] <= 1'b1;
                            "b": disp_en.rgb_enable[2] <= 1'b0;
                            "1": begin
                                disp_en.brightness_enable[5] <= ~disp_en.brightness_enable[5];
                            end
                            "2": begin
                                disp_en.brightness_enable[4] <= ~disp_en.brightness_enable[4];
                            end
                            "3": begin
                                disp_en.brightness_enable[3] <= ~disp_en.brightness_enable[3];
                            end
                            "4": begin
                                disp_en.brightness_enable[2] <= ~disp_en.brightness_enable[2];
                            end
                            "5": begin
                                disp_en.brightness_enable[1] <= ~disp_en.brightness_enable[1];
                            end
                            "6": begin
                                disp_en.brightness_enable[0] <= ~disp_en.brightness_enable[0];
                            end
                            "0": disp_en.brightness_enable <= '0;
                            "9": disp_en.brightness_enable <= '1;
                            "L": state <= dec_row;
                            default: ;
                        endcase
                    end
                    dec_row: begin
                        row <= rx_byte.data[4:0];
                        col <= col_w'(line_bytes - 1);
                        state <= dec_load;
                    end
                    dec_load: begin
                        wr_en <= 1'b1;
                        col <= col - 1'b1;
                        if (col == '0) begin
                            state <= dec_idle;
                            cmd_count <= cmd_count + 1'b1;
                        end
                    end
                    default: state <= dec_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (load_byte) begin
            wr_addr <= pix_addr;
            wr_data <= rx_byte.data;
        end
    end

    assign ram_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                           clk_in,
    input  logic                           reset,
    input  logic                           rx,
    input  logic [led_ctrl_pkg::div_w-1:0] ticks_per_bit,
    output led_ctrl_pkg::rx_byte_t         rx_byte,
    output logic                           rx_busy
);
    import led_ctrl_pkg::*;

    logic [1:0]        rx_sync;
    logic              rx_prev;
    logic [1:0]        state;
    logic [div_w-1:0]  period;
    logic [div_w-1:0]  tick_cnt;
    logic [2:0]        bit_idx;
    logic [data_w-1:0] shift;
    logic              valid;
    logic              rx_line;

    assign rx_line = rx_sync[1];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_prev <= rx_line;
        end
    end

    // the divisor is captured at the start edge and held for the whole frame.
    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= rx_idle;
            tick_cnt <= '0;
            bit_idx <= '0;
            valid <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (state != rx_idle && tick_cnt != '0) begin
                tick_cnt <= tick_cnt - 1'b1;
            end else begin
                case (state)
                    rx_idle: begin
                        if (rx_prev && !rx_line) begin
                            tick_cnt <= ticks_per_bit >> 1;
                            state <= rx_start;
                        end
                    end
                    rx_start: begin
                        tick_cnt <= period - 1'b1;
                        bit_idx <= '0;
                        // a start bit that is high again at its centre was a glitch.
                        state <= rx_line ? rx_idle : rx_data;
                    end
                    rx_data: begin
                        tick_cnt <= period - 1'b1;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end
                    default: begin
                        valid <= rx_line;
                        state <= rx_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == rx_idle && rx_prev && !rx_line) begin
            period <= ticks_per_bit;
        end
        if (state == rx_data && tick_cnt == '0) begin
            shift <= {rx_line, shift[data_w-1:1]};
        end
    end

    assign rx_busy = (state != rx_idle);
    assign rx_byte = '{valid: valid, data: shift};

endmodule

`default_nettype wire

// ==== verilog/led_ctrl_pkg.sv ====
`default_nettype none

package led_ctrl_pkg;

    localparam int data_w = 8;
    localparam int ram_addr_w = 12;
    localparam int div_w = 8;
    localparam logic [div_w-1:0] default_ticks_per_bit = 8'd9;
    localparam int line_bytes = 128;
    localparam int wb_adr_w = 13;

    // word addresses inside the register window.
    localparam logic [7:0] reg_status = 8'd0;
    localparam logic [7:0] reg_divisor = 8'd1;
    localparam logic [7:0] reg_cmd_count = 8'd2;

    localparam logic [1:0] rx_idle = 2'd0;
    localparam logic [1:0] rx_start = 2'd1;
    localparam logic [1:0] rx_data = 2'd2;
    localparam logic [1:0] rx_stop = 2'd3;

    localparam logic [1:0] dec_idle = 2'd0;
    localparam logic [1:0] dec_row = 2'd1;
    localparam logic [1:0] dec_load = 2'd2;

    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
    } rx_byte_t;

    typedef struct packed {
        logic [2:0] rgb_enable;
        logic [5:0] brightness_enable;
    } disp_en_t;

    typedef struct packed {
        logic                  en;
        logic [ram_addr_w-1:0] addr;
        logic [data_w-1:0]     data;
    } ram_wr_t;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [wb_adr_w-1:0] adr;
        logic [data_w-1:0]   dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [data_w-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire
